/* Makefile */
TOP := sdp_tb

all: run

build:
	verilator --binary --timing -Wno-fatal -f sources.f --top-module $(TOP) -o V$(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test passed"

lint:
	verilator --lint-only --timing -f sources.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* logic/sdp_desc_mem.sv */
`timescale 1ns/1ns
`include "sdp_params.svh"

module sdp_desc_mem (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wr,
  input  sdp_mem_pkg::desc_ptr_t wr_ptr,
  input  sdp_mem_pkg::desc_t     wr_desc,
  input  logic                   rd,
  input  sdp_mem_pkg::desc_ptr_t rd_ptr,
  output sdp_mem_pkg::desc_t     rd_desc
);
  import sdp_mem_pkg::*;

  desc_t                       entries [`SDP_DESC_ENTRIES];
  // marks entries written since reset
  logic [`SDP_DESC_ENTRIES-1:0] entry_vld;

  // ----------------------------------------------------------
  // download port
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      entry_vld <= '0;
    else if (wr)
      entry_vld[wr_ptr] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (wr)
      entries[wr_ptr] <= wr_desc;
  end

  // registered read, unwritten entries return zero
  always_ff @(posedge clk)
  begin
    if (rd)
      rd_desc <= entry_vld[rd_ptr] ? entries[rd_ptr] : '0;
  end

endmodule

/* logic/sdp_lane_pkg.sv */
`include "sdp_params.svh"

package sdp_lane_pkg;

  // one bit per execution lane
  typedef logic [`SDP_NUM_LANES-1:0] lane_vec_t;

  // number of enabled lanes, 1 up to SDP_NUM_LANES
  typedef logic [$clog2(`SDP_NUM_LANES+1)-1:0] lane_count_t;

  // word select within a line
  typedef logic [$clog2(`SDP_WORDS_PER_LINE)-1:0] word_ptr_t;

  // request generator states
  typedef enum logic [1:0] {
    REQ_IDLE,
    REQ_FETCH,
    REQ_ISSUE
  } req_state_t;

  // stream controller states
  typedef enum logic {
    STREAM_IDLE,
    STREAM_RUN
  } stream_state_t;

endpackage

/* logic/sdp_mem_pkg.sv */
`include "sdp_params.svh"

package sdp_mem_pkg;

  // address fields of one dram line
  typedef logic [`SDP_LINE_W-1:0]    line_t;
  typedef logic [`SDP_CHANNEL_W-1:0] channel_t;
  typedef logic [`SDP_BANK_W-1:0]    bank_t;
  typedef logic [`SDP_PAGE_W-1:0]    page_t;

  // 16-bit line address, page in the msbs down to line in the lsb
  typedef struct packed {
    page_t    page;
    bank_t    bank;
    channel_t channel;
    line_t    line;
  } dram_addr_t;

  typedef logic [$clog2(`SDP_DESC_ENTRIES)-1:0] desc_ptr_t;
  typedef logic [`SDP_COUNT_W-1:0]              line_count_t;
  typedef logic [`SDP_TAG_W-1:0]                tag_t;

  // one storage descriptor, start line and number of lines
  typedef struct packed {
    dram_addr_t  start_addr;
    line_count_t count;
  } desc_t;

endpackage

/* logic/sdp_params.svh */
`ifndef SDP_PARAMS_SVH
`define SDP_PARAMS_SVH

// ----------------------------------------------------------
// lane and channel geometry
// ----------------------------------------------------------

// execution lanes fed by the stream controller
`define SDP_NUM_LANES       4
// dram channels, one data fifo each
`define SDP_NUM_CHANNELS    2
// words in one memory line
`define SDP_WORDS_PER_LINE  8

// ----------------------------------------------------------
// dram line address fields, lsb first
// ----------------------------------------------------------
`define SDP_LINE_W          1
`define SDP_CHANNEL_W       1
`define SDP_BANK_W          3
`define SDP_PAGE_W          11

// descriptor storage and stream sizes
`define SDP_DESC_ENTRIES    16
`define SDP_COUNT_W         8
`define SDP_TAG_W           4
// response ids in flight between the two parts
`define SDP_ID_DEPTH        4

`endif

/* logic/sdp_request_gen.sv */
`timescale 1ns/1ns
`include "sdp_params.svh"

module sdp_request_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  sdp_mem_pkg::desc_ptr_t desc_ptr,
  input  sdp_mem_pkg::tag_t      tag,
  input  sdp_mem_pkg::desc_t     rd_desc,
  input  logic                   mem_req_ready,
  output logic                   desc_rd,
  output sdp_mem_pkg::desc_ptr_t desc_rd_ptr,
  output logic                   mem_req_valid,
  output sdp_mem_pkg::tag_t      mem_req_tag,
  output sdp_mem_pkg::channel_t  mem_req_channel,
  output sdp_mem_pkg::bank_t     mem_req_bank,
  output sdp_mem_pkg::page_t     mem_req_page,
  output sdp_mem_pkg::line_t     mem_req_line,
  sdp_resp_id_if.src             resp_id
);
  import sdp_mem_pkg::*;
  import sdp_lane_pkg::*;

  localparam int id_ptr_w = $clog2(`SDP_ID_DEPTH);
  localparam logic [id_ptr_w:0] id_depth = `SDP_ID_DEPTH;

  // one queued response id
  typedef struct packed {
    dram_addr_t addr;
    logic       last;
  } id_entry_t;

  req_state_t          state;
  dram_addr_t          addr;
  line_count_t         remaining;
  tag_t                tag_q;
  id_entry_t           id_q [`SDP_ID_DEPTH];
  logic [id_ptr_w-1:0] id_wr;
  logic [id_ptr_w-1:0] id_rd;
  logic [id_ptr_w:0]   id_count;
  logic                id_full;
  logic                push;
  logic                pop;

  // descriptor fetch straight from the start strobe
  assign desc_rd     = start && (state == REQ_IDLE);
  assign desc_rd_ptr = desc_ptr;

  assign id_full       = (id_count == id_depth);
  // no request while every id slot is taken
  assign mem_req_valid = (state == REQ_ISSUE) && !id_full;
  assign mem_req_tag     = tag_q;
  assign mem_req_channel = addr.channel;
  assign mem_req_bank    = addr.bank;
  assign mem_req_page    = addr.page;
  assign mem_req_line    = addr.line;

  assign push = mem_req_valid && mem_req_ready;
  assign pop  = resp_id.valid && resp_id.ready;

  // ----------------------------------------------------------
  // request fsm
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= REQ_IDLE;
      remaining <= '0;
    end
    else
    begin
      case (state)
        REQ_IDLE:
          if (start)
            state <= REQ_FETCH;
        // descriptor is on rd_desc now, load the counters
        REQ_FETCH:
        begin
          remaining <= rd_desc.count;
          state     <= (rd_desc.count == '0) ? REQ_IDLE : REQ_ISSUE;
        end
        REQ_ISSUE:
          if (push)
          begin
            remaining <= remaining - 1'b1;
            if (remaining == line_count_t'(1))
              state <= REQ_IDLE;
          end
        default:
          state <= REQ_IDLE;
      endcase
    end
  end

  // line address walks up one per accepted request, wraps at 16 bits
  always_ff @(posedge clk)
  begin
    if (desc_rd)
      tag_q <= tag;
    if (state == REQ_FETCH)
      addr <= rd_desc.start_addr;
    else if (push)
      addr <= dram_addr_t'(addr + 1'b1);
  end

  // ----------------------------------------------------------
  // response id queue
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_wr    <= '0;
      id_rd    <= '0;
      id_count <= '0;
    end
    else
    begin
      if (push)
        id_wr <= id_wr + 1'b1;
      if (pop)
        id_rd <= id_rd + 1'b1;
      if (push && !pop)
        id_count <= id_count + 1'b1;
      else if (pop && !push)
        id_count <= id_count - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
      id_q[id_wr] <= '{addr: addr, last: (remaining == line_count_t'(1))};
  end

  // queue head
  assign resp_id.valid   = (id_count != '0);
  assign resp_id.channel = id_q[id_rd].addr.channel;
  assign resp_id.bank    = id_q[id_rd].addr.bank;
  assign resp_id.page    = id_q[id_rd].addr.page;
  assign resp_id.line    = id_q[id_rd].addr.line;
  assign resp_id.last    = id_q[id_rd].last;

endmodule

/* logic/sdp_resp_id_if.sv */
`timescale 1ns/1ns
`include "sdp_params.svh"

// response id path, one entry per outstanding memory line
interface sdp_resp_id_if;
  import sdp_mem_pkg::*;

  logic     valid;
  channel_t channel;
  bank_t    bank;
  page_t    page;
  line_t    line;
  // set on the final line of a stream
  logic     last;
  logic     ready;

  // request generator side
  modport src (output valid, channel, bank, page, line, last, input ready);
  // stream controller side
  modport dst (input valid, channel, bank, page, line, last, output ready);

endinterface

/* logic/sdp_stream_cntl.sv */
`timescale 1ns/1ns
`include "sdp_params.svh"

module sdp_stream_cntl (
  input  logic                                       clk,
  input  logic                                       rst_n,
  input  logic                                       start,
  input  sdp_lane_pkg::lane_count_t                  num_lanes,
  input  logic [`SDP_NUM_CHANNELS-1:0]               mem_data_valid,
  input  sdp_lane_pkg::lane_vec_t                    lane_ready,
  output logic [`SDP_NUM_CHANNELS-1:0]               get_next_line,
  output sdp_lane_pkg::lane_vec_t                    lane_valid,
  output sdp_mem_pkg::channel_t                      lane_channel,
  output sdp_lane_pkg::word_ptr_t [`SDP_NUM_LANES-1:0] lane_word_ptr,
  output logic                                       complete,
  sdp_resp_id_if.dst                                 resp_id
);
  import sdp_mem_pkg::*;
  import sdp_lane_pkg::*;

  // one bit wider than a word index, holds index plus lane offset
  localparam int idx_w = $clog2(`SDP_WORDS_PER_LINE) + 1;
  localparam logic [idx_w-1:0] words = `SDP_WORDS_PER_LINE;

  typedef logic [idx_w-1:0] idx_t;

  stream_state_t state;
  lane_count_t   lanes;
  // first word of the current beat
  word_ptr_t     word_idx;
  idx_t          lane_word [`SDP_NUM_LANES];
  lane_vec_t     lane_en;
  logic          start_ok;
  logic          beat_ok;
  logic          last_beat;
  logic          xfer;

  // a zero-count stream never queues an id, so a new start may replace it
  assign start_ok = start && ((state == STREAM_IDLE) || !resp_id.valid);

  // head id has its line waiting in the channel fifo
  assign beat_ok = (state == STREAM_RUN) && resp_id.valid && mem_data_valid[resp_id.channel];

  // ----------------------------------------------------------
  // per-lane word select
  // ----------------------------------------------------------
  always_comb
  begin
    lane_en    = '0;
    lane_valid = '0;
    for (int i = 0; i < `SDP_NUM_LANES; i++)
    begin
      lane_word[i]     = idx_t'(word_idx) + idx_t'(i);
      lane_word_ptr[i] = word_ptr_t'(lane_word[i]);
      lane_en[i]       = (idx_t'(i) < idx_t'(lanes));
      // lanes past the end of the line stay quiet on a partial beat
      lane_valid[i]    = beat_ok && lane_en[i] && (lane_word[i] < words);
    end
  end

  assign lane_channel = resp_id.channel;

  // beat moves only when every enabled lane takes it
  assign xfer      = beat_ok && ((lane_ready & lane_en) == lane_en);
  assign last_beat = (idx_t'(word_idx) + idx_t'(lanes)) >= words;

  // line done, release the id and the channel fifo head
  assign resp_id.ready = xfer && last_beat;

  always_comb
  begin
    get_next_line = '0;
    if (resp_id.ready)
      get_next_line[resp_id.channel] = 1'b1;
  end

  // ----------------------------------------------------------
  // stream fsm and word index
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= STREAM_IDLE;
      lanes    <= lane_count_t'(1);
      word_idx <= '0;
      complete <= 1'b0;
    end
    else
    begin
      // trails the get_next_line of the final line by one cycle
      complete <= resp_id.ready && resp_id.last;
      if (start_ok)
      begin
        state    <= STREAM_RUN;
        lanes    <= num_lanes;
        word_idx <= '0;
      end
      else if (xfer)
      begin
        if (last_beat)
        begin
          word_idx <= '0;
          if (resp_id.last)
            state <= STREAM_IDLE;
        end
        else
          word_idx <= word_ptr_t'(word_idx + lanes);
      end
    end
  end

endmodule

/* logic/sdp_top.sv */
`timescale 1ns/1ns
`include "sdp_params.svh"

module sdp_top (
  input  logic                                         clk,
  input  logic                                         rst_n,
  // descriptor download
  input  logic                                         desc_wr,
  input  sdp_mem_pkg::desc_ptr_t                       desc_wr_ptr,
  input  sdp_mem_pkg::dram_addr_t                      desc_wr_addr,
  input  sdp_mem_pkg::line_count_t                     desc_wr_count,
  // stream start
  input  logic                                         start,
  input  sdp_mem_pkg::desc_ptr_t                       desc_ptr,
  input  sdp_mem_pkg::tag_t                            tag,
  input  sdp_lane_pkg::lane_count_t                    num_lanes,
  // memory request port
  output logic                                         mem_req_valid,
  output sdp_mem_pkg::tag_t                            mem_req_tag,
  output sdp_mem_pkg::channel_t                        mem_req_channel,
  output sdp_mem_pkg::bank_t                           mem_req_bank,
  output sdp_mem_pkg::page_t                           mem_req_page,
  output sdp_mem_pkg::line_t                           mem_req_line,
  input  logic                                         mem_req_ready,
  input  logic [`SDP_NUM_CHANNELS-1:0]                 mem_data_valid,
  output logic [`SDP_NUM_CHANNELS-1:0]                 get_next_line,
  // lanes
  output sdp_lane_pkg::lane_vec_t                      lane_valid,
  output sdp_mem_pkg::channel_t                        lane_channel,
  output sdp_lane_pkg::word_ptr_t [`SDP_NUM_LANES-1:0] lane_word_ptr,
  input  sdp_lane_pkg::lane_vec_t                      lane_ready,
  output logic                                         complete
);
  import sdp_mem_pkg::*;

  desc_t     wr_desc;
  desc_t     rd_desc;
  logic      desc_rd;
  desc_ptr_t desc_rd_ptr;

  sdp_resp_id_if resp_id ();

  assign wr_desc = '{start_addr: desc_wr_addr, count: desc_wr_count};

  // ----------------------------------------------------------
  // descriptor storage and request side
  // ----------------------------------------------------------
  sdp_desc_mem i_desc_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr      (desc_wr),
    .wr_ptr  (desc_wr_ptr),
    .wr_desc (wr_desc),
    .rd      (desc_rd),
    .rd_ptr  (desc_rd_ptr),
    .rd_desc (rd_desc)
  );

  sdp_request_gen i_request_gen (
    .clk             (clk),
    .rst_n           (rst_n),
    .start           (start),
    .desc_ptr        (desc_ptr),
    .tag             (tag),
    .rd_desc         (rd_desc),
    .mem_req_ready   (mem_req_ready),
    .desc_rd         (desc_rd),
    .desc_rd_ptr     (desc_rd_ptr),
    .mem_req_valid   (mem_req_valid),
    .mem_req_tag     (mem_req_tag),
    .mem_req_channel (mem_req_channel),
    .mem_req_bank    (mem_req_bank),
    .mem_req_page    (mem_req_page),
    .mem_req_line    (mem_req_line),
    .resp_id         (resp_id.src)
  );

  // lane side, same start strobe
  sdp_stream_cntl i_stream_cntl (
    .clk            (clk),
    .rst_n          (rst_n),
    .start          (start),
    .num_lanes      (num_lanes),
    .mem_data_valid (mem_data_valid),
    .lane_ready     (lane_ready),
    .get_next_line  (get_next_line),
    .lane_valid     (lane_valid),
    .lane_channel   (lane_channel),
    .lane_word_ptr  (lane_word_ptr),
    .complete       (complete),
    .resp_id        (resp_id.dst)
  );

endmodule

/* sources.f */
+incdir+logic
logic/sdp_mem_pkg.sv
logic/sdp_lane_pkg.sv
logic/sdp_resp_id_if.sv
logic/sdp_desc_mem.sv
logic/sdp_request_gen.sv
logic/sdp_stream_cntl.sv
logic/sdp_top.sv
verification/sdp_clk_gen.sv
verification/sdp_tb.sv

/* verification/sdp_cases.txt */
# d <descriptor index> <start line address> <line count>, all hex
# s <descriptor index> <tag> <lane count>, all hex
d 0 0000 03
d 1 001e 05
d 2 ffff 04
d 3 07fc 02
d 5 fff8 0a
s 0 1 1
s 1 2 2
s 2 3 3
s 3 4 4
s 9 5 4
d 2 0100 06
s 2 6 3
d 4 0040 00
s 4 7 2
s 5 8 1
s 1 9 4
d 0 3ffd 07
s 0 a 3
s 5 b 2

/* verification/sdp_clk_gen.sv */
`timescale 1ns/1ns

module sdp_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 20 ns period
  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  // reset low over the first three rising edges
  initial
  begin
    rst_n = 1'b0;
    repeat (3)
      @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

/* verification/sdp_tb.sv */
`timescale 1ns/1ns
`include "sdp_params.svh"

module sdp_tb;
  import sdp_mem_pkg::*;
  import sdp_lane_pkg::*;

  localparam int timeout_cycles = 2000;

  logic                         clk;
  logic                         rst_n;
  logic                         desc_wr;
  desc_ptr_t                    desc_wr_ptr;
  dram_addr_t                   desc_wr_addr;
  line_count_t                  desc_wr_count;
  logic                         start;
  desc_ptr_t                    desc_ptr;
  tag_t                         tag;
  lane_count_t                  num_lanes;
  logic                         mem_req_valid;
  tag_t                         mem_req_tag;
  channel_t                     mem_req_channel;
  bank_t                        mem_req_bank;
  page_t                        mem_req_page;
  line_t                        mem_req_line;
  logic                         mem_req_ready;
  logic [`SDP_NUM_CHANNELS-1:0] mem_data_valid;
  logic [`SDP_NUM_CHANNELS-1:0] get_next_line;
  lane_vec_t                    lane_valid;
  channel_t                     lane_channel;
  word_ptr_t [`SDP_NUM_LANES-1:0] lane_word_ptr;
  lane_vec_t                    lane_ready;
  logic                         complete;

  // local descriptor copy holds zero where never downloaded
  logic [15:0] desc_addr [`SDP_DESC_ENTRIES];
  logic [7:0]  desc_count [`SDP_DESC_ENTRIES];

  // expected stream values set before each start
  logic [15:0] stream_addr;
  int          stream_count;
  tag_t        stream_tag;
  int          stream_lanes = 1;

  // monitor state
  int          req_n;
  int          lines_done;
  int          word_exp;
  int          complete_seen;
  int          pop_count;
  logic        stall_q;
  logic [19:0] held_req;
  logic        complete_exp;
  // channels of accepted requests with the streamed line at the head
  channel_t    line_q [$];

  int          errors;
  int          streams;
  logic        timed_out;

  sdp_clk_gen i_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  sdp_top i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .desc_wr         (desc_wr),
    .desc_wr_ptr     (desc_wr_ptr),
    .desc_wr_addr    (desc_wr_addr),
    .desc_wr_count   (desc_wr_count),
    .start           (start),
    .desc_ptr        (desc_ptr),
    .tag             (tag),
    .num_lanes       (num_lanes),
    .mem_req_valid   (mem_req_valid),
    .mem_req_tag     (mem_req_tag),
    .mem_req_channel (mem_req_channel),
    .mem_req_bank    (mem_req_bank),
    .mem_req_page    (mem_req_page),
    .mem_req_line    (mem_req_line),
    .mem_req_ready   (mem_req_ready),
    .mem_data_valid  (mem_data_valid),
    .get_next_line   (get_next_line),
    .lane_valid      (lane_valid),
    .lane_channel    (lane_channel),
    .lane_word_ptr   (lane_word_ptr),
    .lane_ready      (lane_ready),
    .complete        (complete)
  );

  task automatic report_error(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  // ------------------------------------------------------------
  // memory model driven 1 ns after the rising edge
  // ------------------------------------------------------------
  initial
  begin
    int data_wait;
    int pops_seen;
    void'($urandom(40005));
    mem_req_ready  = 1'b0;
    mem_data_valid = '0;
    lane_ready     = '0;
    data_wait      = 0;
    pops_seen      = 0;
    forever
    begin
      @(posedge clk);
      #1;
      mem_req_ready = ($urandom % 4) != 0;
      for (int i = 0; i < `SDP_NUM_LANES; i++)
        lane_ready[i] = ($urandom % 8) != 0;
      // a new head line shows up 0 to 3 cycles later
      if (pops_seen != pop_count)
      begin
        pops_seen = pop_count;
        data_wait = $urandom_range(3, 0);
      end
      mem_data_valid = '0;
      if (line_q.size() != 0)
      begin
        if (data_wait > 0)
          data_wait--;
        else
          mem_data_valid[line_q[0]] = 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // per-cycle checks on the falling edge
  // ------------------------------------------------------------
  task automatic check_cycle();
    logic [15:0]                  got_addr;
    logic [15:0]                  exp_addr;
    logic [`SDP_NUM_CHANNELS-1:0] exp_gnl;
    lane_vec_t                    lane_en;
    logic                         lane_xfer;
    logic                         line_end;
    logic                         exp_v;
    int                           w;
    got_addr = {mem_req_page, mem_req_bank, mem_req_channel, mem_req_line};
    if (start)
    begin
      req_n      = 0;
      lines_done = 0;
      word_exp   = 0;
    end
    // request must hold while the memory stalls it
    if (stall_q && (!mem_req_valid || {mem_req_tag, got_addr} != held_req))
      report_error("memory request changed while stalled");
    stall_q  = mem_req_valid && !mem_req_ready;
    held_req = {mem_req_tag, got_addr};
    for (int i = 0; i < `SDP_NUM_LANES; i++)
      lane_en[i] = (i < stream_lanes);
    lane_xfer = (lane_valid != '0) && ((lane_ready & lane_en) == lane_en);
    line_end  = 1'b0;
    if (lane_valid != '0 && line_q.size() == 0)
      report_error("lane beat with no outstanding request");
    else if (lane_valid != '0 && !mem_data_valid[line_q[0]])
      report_error("lane beat before the line data is valid");
    else if (lane_xfer)
    begin
      if (lane_channel != line_q[0])
        report_error($sformatf("lane_channel %0d, head channel %0d", lane_channel, line_q[0]));
      w = word_exp;
      for (int i = 0; i < `SDP_NUM_LANES; i++)
      begin
        exp_v = (i < stream_lanes) && (w + i < `SDP_WORDS_PER_LINE);
        if (lane_valid[i] != exp_v)
          report_error($sformatf("lane %0d valid %0b at word %0d", i, lane_valid[i], w));
        else if (exp_v && lane_word_ptr[i] != word_ptr_t'(w + i))
          report_error($sformatf("lane %0d word %0d, expected %0d", i, lane_word_ptr[i], w + i));
        if (exp_v)
          word_exp++;
      end
      line_end = (word_exp >= `SDP_WORDS_PER_LINE);
    end
    // get_next_line only with the beat holding the last word
    exp_gnl = '0;
    if (line_end)
      exp_gnl[line_q[0]] = 1'b1;
    if (get_next_line != exp_gnl)
      report_error($sformatf("get_next_line %b, expected %b", get_next_line, exp_gnl));
    if (complete != complete_exp)
      report_error($sformatf("complete %0b, expected %0b", complete, complete_exp));
    if (complete)
      complete_seen++;
    complete_exp = 1'b0;
    if (line_end)
    begin
      void'(line_q.pop_front());
      pop_count++;
      word_exp = 0;
      lines_done++;
      if (lines_done == stream_count)
        complete_exp = 1'b1;
    end
    // accepted request n lies n lines past the descriptor start
    if (mem_req_valid && mem_req_ready)
    begin
      exp_addr = stream_addr + req_n[15:0];
      if (req_n >= stream_count)
        report_error($sformatf("extra request %0d, stream count %0d", req_n, stream_count));
      else if (got_addr != exp_addr || mem_req_tag != stream_tag)
        report_error($sformatf("request %0d addr %h tag %h, expected %h tag %h",
                               req_n, got_addr, mem_req_tag, exp_addr, stream_tag));
      line_q.push_back(channel_t'(exp_addr[`SDP_LINE_W +: `SDP_CHANNEL_W]));
      req_n++;
    end
  endtask

  always @(negedge clk)
  begin
    if (rst_n)
      check_cycle();
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  task automatic download(input int idx, input int addr, input int count);
    @(posedge clk);
    #1;
    desc_wr          = 1'b1;
    desc_wr_ptr      = desc_ptr_t'(idx);
    desc_wr_addr     = dram_addr_t'(addr[15:0]);
    desc_wr_count    = line_count_t'(count);
    desc_addr[idx]   = addr[15:0];
    desc_count[idx]  = count[7:0];
    @(posedge clk);
    #1;
    desc_wr = 1'b0;
  endtask

  task automatic run_stream(input int idx, input int new_tag, input int lanes);
    int done_before;
    int cycles;
    stream_addr  = desc_addr[idx];
    stream_count = desc_count[idx];
    stream_tag   = tag_t'(new_tag);
    stream_lanes = lanes;
    done_before  = complete_seen;
    streams++;
    @(posedge clk);
    #1;
    start     = 1'b1;
    desc_ptr  = desc_ptr_t'(idx);
    tag       = tag_t'(new_tag);
    num_lanes = lane_count_t'(lanes);
    @(posedge clk);
    #1;
    start = 1'b0;
    // descriptor read and counter load come before the first request
    @(negedge clk);
    if (mem_req_valid)
      report_error("request during descriptor fetch");
    @(negedge clk);
    if (mem_req_valid != (stream_count != 0))
      report_error($sformatf("first request valid %0b, count %0d", mem_req_valid, stream_count));
    if (stream_count == 0)
    begin
      // an empty stream stays silent
      cycles = 0;
      while (cycles < 10)
      begin
        @(posedge clk);
        cycles++;
      end
      if (req_n != 0 || complete_seen != done_before)
        report_error("activity on a stream with count zero");
    end
    else
    begin
      cycles = 0;
      while (complete_seen == done_before && cycles < timeout_cycles)
      begin
        @(posedge clk);
        cycles++;
      end
      if (complete_seen == done_before)
      begin
        $display("timeout: stream with tag %0h never signalled complete", new_tag);
        timed_out = 1'b1;
      end
      else if (req_n != stream_count || lines_done != stream_count)
        report_error($sformatf("%0d requests and %0d lines, expected %0d",
                               req_n, lines_done, stream_count));
    end
  endtask

  // records are d or s followed by three hex fields
  task automatic run_cases(input int fd);
    string line;
    byte   kind;
    int    f1;
    int    f2;
    int    f3;
    int    n;
    while (!timed_out && $fgets(line, fd) != 0)
    begin
      if (line.len() > 1 && line[0] != "#")
      begin
        n = $sscanf(line, "%c %h %h %h", kind, f1, f2, f3);
        if (n == 4 && kind == "d")
          download(f1, f2, f3);
        else if (n == 4 && kind == "s")
          run_stream(f1, f2, f3);
        else
        begin
          $display("cases file holds an unreadable record: %s", line);
          errors++;
        end
      end
    end
  endtask

  initial
  begin
    int fd;
    int cycles;
    desc_wr       = 1'b0;
    desc_wr_ptr   = '0;
    desc_wr_addr  = '0;
    desc_wr_count = '0;
    start         = 1'b0;
    desc_ptr      = '0;
    tag           = '0;
    num_lanes     = lane_count_t'(1);
    stream_addr   = '0;
    stream_count  = 0;
    stream_tag    = '0;
    stall_q       = 1'b0;
    held_req      = '0;
    complete_exp  = 1'b0;
    timed_out     = 1'b0;
    for (int i = 0; i < `SDP_DESC_ENTRIES; i++)
    begin
      desc_addr[i]  = '0;
      desc_count[i] = '0;
    end
    cycles = 0;
    while (!rst_n && cycles < 20)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!rst_n)
    begin
      $display("timeout: reset was never released");
      timed_out = 1'b1;
    end
    else
    begin
      // quiet outputs before the first start
      repeat (3)
      begin
        @(negedge clk);
        if (mem_req_valid || lane_valid != '0 || get_next_line != '0 || complete)
          report_error("output active after reset");
      end
      fd = $fopen("verification/sdp_cases.txt", "r");
      if (fd == 0)
      begin
        $display("could not open verification/sdp_cases.txt");
        errors++;
      end
      else
      begin
        run_cases(fd);
        $fclose(fd);
      end
    end
    $display("streams run %0d, errors %0d", streams, errors);
    if (errors == 0 && !timed_out)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
